//--- src/lane_pkg.sv
// Shared definitions for the lane operand router
// Lane data word and operand-queue entry types
// Reduced vector operation codes
// Bus selector and data mux encodings
// Default queue depths

package lane_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ElenWidth = 64;

  typedef logic [ElenWidth-1:0] elen_t;

  // One operand plus the end-of-instruction marker
  typedef struct packed {
    logic  last;
    elen_t data;
  } opq_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////////////////////////////////////////

  // Reduction groups are kept contiguous so they decode as ranges
  typedef enum logic [4:0] {
    VADD,
    VMUL,
    VSLIDEUP,
    VSLIDEDOWN,
    VLXE,
    VSXE,
    VREDSUM,
    VREDMAX,
    VWREDSUM,
    VFREDUSUM,
    VFREDOSUM,
    VFWREDOSUM
  } ara_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bus arbitration
  ////////////////////////////////////////////////////////////////////////////

  // Owner of the shared operand bus
  typedef enum logic [1:0] {
    SLDU_SEL    = 2'd0,
    ADDRGEN_SEL = 2'd1,
    ALU_RED_SEL = 2'd2,
    FPU_RED_SEL = 2'd3
  } sel_e;

  // Source feeding bus_data_o
  typedef enum logic [1:0] {
    MUX_OPQUEUE_SEL = 2'd0,
    MUX_ALU_SEL     = 2'd1,
    MUX_FPU_SEL     = 2'd2
  } mux_sel_e;

  localparam int unsigned NrVInsnDefault  = 8;
  localparam int unsigned OpqDepthDefault = 4;

endpackage : lane_pkg

//--- src/op_classifier.sv
// Operation classifier
// One registered stage that decodes accepted operations into
// bus selector entries for the order FIFO

`timescale 1ns/1ps

module op_classifier import lane_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    flush_i,
  // Incoming operations
  input  logic    op_valid_i,
  input  ara_op_e op_i,
  output logic    op_ready_o,
  // Selector entries towards the FIFO
  output logic    sel_valid_o,
  output sel_e    sel_o,
  input  logic    sel_ready_i
);

  logic    op_valid_q;
  ara_op_e op_q;
  logic    routed;

  // Stage is free when empty, discarded, or moving out this cycle
  assign op_ready_o = !sel_valid_o || sel_ready_i;

  // Flush drops the stage and anything arriving alongside it
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_valid_q <= 1'b0;
      op_q       <= VADD;
    end else if (flush_i) begin
      op_valid_q <= 1'b0;
    end else if (op_ready_o) begin
      op_valid_q <= op_valid_i;
      op_q       <= op_i;
    end
  end

  // Decode the registered code
  always_comb begin
    routed = 1'b1;
    sel_o  = SLDU_SEL;
    case (op_q) inside
      VSLIDEUP, VSLIDEDOWN:  sel_o = SLDU_SEL;
      VLXE, VSXE:            sel_o = ADDRGEN_SEL;
      [VREDSUM:VWREDSUM]:    sel_o = ALU_RED_SEL;
      [VFREDUSUM:VFWREDOSUM]: sel_o = FPU_RED_SEL;
      // Plain arithmetic never touches the shared bus
      default:               routed = 1'b0;
    endcase
  end

  assign sel_valid_o = op_valid_q && routed;

  // A waiting entry holds still until the FIFO takes it
  a_sel_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    sel_valid_o && !sel_ready_i && !flush_i |=> sel_valid_o && $stable(sel_o));

endmodule : op_classifier

//--- src/order_fifo.sv
// Generic flushable FIFO
// Circular buffer with read/write pointers and an occupancy count
// Payload type is set per instance

`timescale 1ns/1ps

module order_fifo #(
  parameter type         entry_t = logic,
  parameter int unsigned Depth   = 2
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  logic   flush_i,
  // Push side
  input  logic   valid_i,
  input  entry_t data_i,
  output logic   ready_o,
  // Pop side
  output logic   valid_o,
  output entry_t data_o,
  input  logic   pop_i
);

  localparam int unsigned PtrWidth = $clog2(Depth);
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  entry_t                mem_q [Depth];
  logic   [PtrWidth-1:0] wr_ptr_q;
  logic   [PtrWidth-1:0] rd_ptr_q;
  logic   [CntWidth-1:0] count_q;
  logic                  push;
  logic                  pop;

  assign ready_o = (count_q != CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = pop_i && valid_o;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Consumer only pops a visible head
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> valid_o);

  // A push refused while full is held by the producer
  a_push_held_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i && !ready_o && !flush_i |=> valid_i && $stable(data_i));

endmodule : order_fifo

//--- src/operand_bus_arbiter.sv
// Shared operand bus arbiter
// Head selector picks the bus owner: operand queue, ALU or FPU reduction
// Operand valid demux between slide unit and address generator
// Reduction valid steering and selector/operand pop decisions

`timescale 1ns/1ps

module operand_bus_arbiter import lane_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Selector FIFO head
  input  logic      sel_valid_i,
  input  sel_e      sel_i,
  output logic      sel_pop_o,
  // Operand FIFO head
  input  logic      opq_valid_i,
  input  opq_word_t opq_i,
  output logic      opq_pop_o,
  // Reduction sources
  input  elen_t     alu_red_data_i,
  input  elen_t     fpu_red_data_i,
  output logic      alu_red_gnt_o,
  output logic      fpu_red_gnt_o,
  input  logic      alu_red_done_i,
  input  logic      fpu_red_done_i,
  // Reduction valid from the slide unit
  input  logic      sldu_red_valid_i,
  output logic      sldu_red_ready_o,
  output logic      alu_red_in_valid_o,
  output logic      fpu_red_in_valid_o,
  input  logic      alu_red_in_ready_i,
  input  logic      fpu_red_in_ready_i,
  // Shared bus
  output elen_t     bus_data_o,
  output logic      sldu_valid_o,
  output logic      addrgen_valid_o,
  input  logic      sldu_ready_i,
  input  logic      addrgen_ready_i
);

  logic     own_sldu;
  logic     own_addrgen;
  logic     own_alu;
  logic     own_fpu;
  logic     opq_ready;
  mux_sel_e mux_sel;

  // Owner decode, nothing owns the bus with an empty selector FIFO
  assign own_sldu    = sel_valid_i && (sel_i == SLDU_SEL);
  assign own_addrgen = sel_valid_i && (sel_i == ADDRGEN_SEL);
  assign own_alu     = sel_valid_i && (sel_i == ALU_RED_SEL);
  assign own_fpu     = sel_valid_i && (sel_i == FPU_RED_SEL);

  ////////////////////////////////////////////////////////////////////////////
  // Bus data mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (sel_i)
      ALU_RED_SEL: mux_sel = MUX_ALU_SEL;
      FPU_RED_SEL: mux_sel = MUX_FPU_SEL;
      default:     mux_sel = MUX_OPQUEUE_SEL;
    endcase
  end

  always_comb begin
    case (mux_sel)
      MUX_ALU_SEL: bus_data_o = alu_red_data_i;
      MUX_FPU_SEL: bus_data_o = fpu_red_data_i;
      default:     bus_data_o = opq_i.data;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid demux and grants
  ////////////////////////////////////////////////////////////////////////////

  // Reductions present their data as soon as they own the bus
  assign sldu_valid_o    = (own_sldu && opq_valid_i) || own_alu || own_fpu;
  assign addrgen_valid_o = own_addrgen && opq_valid_i;

  assign alu_red_gnt_o = own_alu && sldu_ready_i;
  assign fpu_red_gnt_o = own_fpu && sldu_ready_i;

  // Ready back to the operand queue comes from whichever side owns it
  assign opq_ready = (own_sldu && sldu_ready_i) || (own_addrgen && addrgen_ready_i);
  assign opq_pop_o = opq_valid_i && opq_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Reduction valid steering
  ////////////////////////////////////////////////////////////////////////////

  assign alu_red_in_valid_o = sldu_red_valid_i && own_alu;
  assign fpu_red_in_valid_o = sldu_red_valid_i && own_fpu;

  always_comb begin
    sldu_red_ready_o = 1'b0;
    if (own_alu) begin
      sldu_red_ready_o = alu_red_in_ready_i;
    end else if (own_fpu) begin
      sldu_red_ready_o = fpu_red_in_ready_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Selector pop
  ////////////////////////////////////////////////////////////////////////////

  // Operand streams retire with their last operand, reductions on done
  always_comb begin
    sel_pop_o = 1'b0;
    if (own_sldu || own_addrgen) begin
      sel_pop_o = opq_pop_o && opq_i.last;
    end else if (own_alu) begin
      sel_pop_o = alu_red_done_i;
    end else if (own_fpu) begin
      sel_pop_o = fpu_red_done_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  a_one_operand_sink : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(sldu_valid_o && addrgen_valid_o));

  // A reduction only completes while its selector is at the head
  a_red_done_owned : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (alu_red_done_i |-> own_alu) and (fpu_red_done_i |-> own_fpu));

endmodule : operand_bus_arbiter

//--- src/lane_operand_router.sv
// Lane operand router top level
// Operation classifier feeding an in-order selector FIFO
// Operand FIFO for slide and indexed memory operands
// Bus arbiter sharing one operand bus among slide unit,
// address generator and the ALU/FPU reduction paths

`timescale 1ns/1ps

module lane_operand_router import lane_pkg::*; #(
  parameter int unsigned NrVInsn  = NrVInsnDefault,
  parameter int unsigned OpqDepth = OpqDepthDefault
) (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    flush_i,
  // Operations
  input  logic    op_valid_i,
  input  ara_op_e op_i,
  output logic    op_ready_o,
  // Operand stream
  input  logic    opq_valid_i,
  input  elen_t   opq_data_i,
  input  logic    opq_last_i,
  output logic    opq_ready_o,
  // Reduction sources
  input  elen_t   alu_red_data_i,
  input  elen_t   fpu_red_data_i,
  output logic    alu_red_gnt_o,
  output logic    fpu_red_gnt_o,
  input  logic    alu_red_done_i,
  input  logic    fpu_red_done_i,
  // Slide unit reduction valid
  input  logic    sldu_red_valid_i,
  output logic    sldu_red_ready_o,
  output logic    alu_red_in_valid_o,
  output logic    fpu_red_in_valid_o,
  input  logic    alu_red_in_ready_i,
  input  logic    fpu_red_in_ready_i,
  // Shared bus
  output elen_t   bus_data_o,
  output logic    sldu_valid_o,
  output logic    addrgen_valid_o,
  input  logic    sldu_ready_i,
  input  logic    addrgen_ready_i
);

  // Classifier to selector FIFO
  logic      cls_valid;
  sel_e      cls_sel;
  logic      cls_ready;
  // Selector FIFO head
  logic      sel_valid;
  sel_e      sel_head;
  logic      sel_pop;
  // Operand FIFO
  opq_word_t opq_word;
  logic      opq_valid;
  opq_word_t opq_head;
  logic      opq_pop;

  assign opq_word = '{last: opq_last_i, data: opq_data_i};

  ////////////////////////////////////////////////////////////////////////////
  // Classification and ordering
  ////////////////////////////////////////////////////////////////////////////

  op_classifier u_classifier (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .flush_i    (flush_i),
    .op_valid_i (op_valid_i),
    .op_i       (op_i),
    .op_ready_o (op_ready_o),
    .sel_valid_o(cls_valid),
    .sel_o      (cls_sel),
    .sel_ready_i(cls_ready)
  );

  order_fifo #(
    .entry_t(sel_e),
    .Depth  (NrVInsn)
  ) u_sel_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .flush_i (flush_i),
    .valid_i (cls_valid),
    .data_i  (cls_sel),
    .ready_o (cls_ready),
    .valid_o (sel_valid),
    .data_o  (sel_head),
    .pop_i   (sel_pop)
  );

  order_fifo #(
    .entry_t(opq_word_t),
    .Depth  (OpqDepth)
  ) u_opq_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .flush_i (flush_i),
    .valid_i (opq_valid_i),
    .data_i  (opq_word),
    .ready_o (opq_ready_o),
    .valid_o (opq_valid),
    .data_o  (opq_head),
    .pop_i   (opq_pop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Bus arbitration
  ////////////////////////////////////////////////////////////////////////////

  operand_bus_arbiter u_arbiter (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .sel_valid_i       (sel_valid),
    .sel_i             (sel_head),
    .sel_pop_o         (sel_pop),
    .opq_valid_i       (opq_valid),
    .opq_i             (opq_head),
    .opq_pop_o         (opq_pop),
    .alu_red_data_i    (alu_red_data_i),
    .fpu_red_data_i    (fpu_red_data_i),
    .alu_red_gnt_o     (alu_red_gnt_o),
    .fpu_red_gnt_o     (fpu_red_gnt_o),
    .alu_red_done_i    (alu_red_done_i),
    .fpu_red_done_i    (fpu_red_done_i),
    .sldu_red_valid_i  (sldu_red_valid_i),
    .sldu_red_ready_o  (sldu_red_ready_o),
    .alu_red_in_valid_o(alu_red_in_valid_o),
    .fpu_red_in_valid_o(fpu_red_in_valid_o),
    .alu_red_in_ready_i(alu_red_in_ready_i),
    .fpu_red_in_ready_i(fpu_red_in_ready_i),
    .bus_data_o        (bus_data_o),
    .sldu_valid_o      (sldu_valid_o),
    .addrgen_valid_o   (addrgen_valid_o),
    .sldu_ready_i      (sldu_ready_i),
    .addrgen_ready_i   (addrgen_ready_i)
  );

  // Pointer wrap logic needs at least two entries
  if (NrVInsn < 2 || OpqDepth < 2) begin : g_depth_check
    $error("lane_operand_router: FIFO depths must be at least 2");
  end

endmodule : lane_operand_router

//--- sim/tb_ref_model.svh
// Reference model for the lane operand router testbench
// Expected selector and operand queues in issue order
// Routing of operation codes to bus owners
// Grant tracking for the reduction done responder

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

  sel_e      sel_exp[$];
  opq_word_t opd_exp[$];
  bit        alu_granted;
  bit        fpu_granted;

  // Bus owner of each routed operation code
  function automatic bit route_of(ara_op_e op, output sel_e sel);
    sel      = SLDU_SEL;
    route_of = 1'b1;
    case (op)
      VSLIDEUP, VSLIDEDOWN:             sel = SLDU_SEL;
      VLXE, VSXE:                       sel = ADDRGEN_SEL;
      VREDSUM, VREDMAX, VWREDSUM:       sel = ALU_RED_SEL;
      VFREDUSUM, VFREDOSUM, VFWREDOSUM: sel = FPU_RED_SEL;
      default:                          route_of = 1'b0;
    endcase
  endfunction

  task automatic record_op(ara_op_e op);
    sel_e sel;
    if (route_of(op, sel)) begin
      sel_exp.push_back(sel);
    end
  endtask

  task automatic record_operand(elen_t data, logic last);
    opq_word_t word;
    word.data = data;
    word.last = last;
    opd_exp.push_back(word);
  endtask

  task automatic retire_head();
    void'(sel_exp.pop_front());
  endtask

  task automatic clear_model();
    sel_exp.delete();
    opd_exp.delete();
    alu_granted = 1'b0;
    fpu_granted = 1'b0;
  endtask

  function automatic bit model_empty();
    return (sel_exp.size() == 0) && (opd_exp.size() == 0);
  endfunction

`endif

//--- sim/tb_lane_operand_router.sv
// Testbench for the lane operand router
// Clock, reset and random operation and operand streams
// Random back-pressure and a reduction done responder
// Bus monitor against the reference model, watchdog and report

`timescale 1ns/1ps

module tb_lane_operand_router import lane_pkg::*; ();

  localparam int unsigned SlideOps = 12;
  localparam int unsigned IndexOps = 12;
  localparam int unsigned RedOps   = 12;
  localparam int unsigned MixOps   = 60;
  localparam int unsigned FlushOps = 13;
  localparam int unsigned TotalOps = SlideOps + IndexOps + RedOps + MixOps + FlushOps;

  // Chance of an idle cycle ahead of each push, in percent
  localparam int unsigned IdlePct = 20;

  logic    clk_i;
  logic    arst_n_i;
  logic    flush_i;
  logic    op_valid_i;
  ara_op_e op_i;
  logic    op_ready_o;
  logic    opq_valid_i;
  elen_t   opq_data_i;
  logic    opq_last_i;
  logic    opq_ready_o;
  elen_t   alu_red_data_i;
  elen_t   fpu_red_data_i;
  logic    alu_red_gnt_o;
  logic    fpu_red_gnt_o;
  logic    alu_red_done_i;
  logic    fpu_red_done_i;
  logic    sldu_red_valid_i;
  logic    sldu_red_ready_o;
  logic    alu_red_in_valid_o;
  logic    fpu_red_in_valid_o;
  logic    alu_red_in_ready_i;
  logic    fpu_red_in_ready_i;
  elen_t   bus_data_o;
  logic    sldu_valid_o;
  logic    addrgen_valid_o;
  logic    sldu_ready_i;
  logic    addrgen_ready_i;

  int unsigned ready_pct = 80;
  bit          hold_bus  = 1'b0;
  int          errors    = 0;
  int          tests_run = 0;
  int          tests_bad = 0;

  `include "tb_ref_model.svh"

  lane_operand_router #(
    .NrVInsn (NrVInsnDefault),
    .OpqDepth(OpqDepthDefault)
  ) lane_operand_router_inst (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .flush_i           (flush_i),
    .op_valid_i        (op_valid_i),
    .op_i              (op_i),
    .op_ready_o        (op_ready_o),
    .opq_valid_i       (opq_valid_i),
    .opq_data_i        (opq_data_i),
    .opq_last_i        (opq_last_i),
    .opq_ready_o       (opq_ready_o),
    .alu_red_data_i    (alu_red_data_i),
    .fpu_red_data_i    (fpu_red_data_i),
    .alu_red_gnt_o     (alu_red_gnt_o),
    .fpu_red_gnt_o     (fpu_red_gnt_o),
    .alu_red_done_i    (alu_red_done_i),
    .fpu_red_done_i    (fpu_red_done_i),
    .sldu_red_valid_i  (sldu_red_valid_i),
    .sldu_red_ready_o  (sldu_red_ready_o),
    .alu_red_in_valid_o(alu_red_in_valid_o),
    .fpu_red_in_valid_o(fpu_red_in_valid_o),
    .alu_red_in_ready_i(alu_red_in_ready_i),
    .fpu_red_in_ready_i(fpu_red_in_ready_i),
    .bus_data_o        (bus_data_o),
    .sldu_valid_o      (sldu_valid_o),
    .addrgen_valid_o   (addrgen_valid_o),
    .sldu_ready_i      (sldu_ready_i),
    .addrgen_ready_i   (addrgen_ready_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(TotalOps * 200);
    $display("Timeout at %0t ns: the operand streams did not drain", $time);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_bit(string name, logic act, logic exp);
    assert (act === exp) else begin
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic check_word(string name, elen_t act, elen_t exp);
    assert (act === exp) else begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic check_true(bit cond, string what);
    assert (cond) else begin
      $display("Failure at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic check_idle();
    check_bit("sldu_valid_o", sldu_valid_o, 1'b0);
    check_bit("addrgen_valid_o", addrgen_valid_o, 1'b0);
    check_bit("alu_red_gnt_o", alu_red_gnt_o, 1'b0);
    check_bit("fpu_red_gnt_o", fpu_red_gnt_o, 1'b0);
    check_bit("alu_red_in_valid_o", alu_red_in_valid_o, 1'b0);
    check_bit("fpu_red_in_valid_o", fpu_red_in_valid_o, 1'b0);
    check_bit("op_ready_o", op_ready_o, 1'b1);
    check_bit("opq_ready_o", opq_ready_o, 1'b1);
  endtask

  task automatic take_operand(logic ready);
    opq_word_t want;
    check_bit("sldu_red_ready_o", sldu_red_ready_o, 1'b0);
    check_true(opd_exp.size() != 0, "operand on the bus that was never issued");
    if (opd_exp.size() != 0) begin
      want = opd_exp[0];
      check_word("bus_data_o", bus_data_o, want.data);
      if (ready) begin
        void'(opd_exp.pop_front());
        // The last operand retires its instruction
        if (want.last) begin
          retire_head();
        end
      end
    end
  endtask

  task automatic take_reduction(bit is_fpu);
    logic done;
    check_word("bus_data_o", bus_data_o, is_fpu ? fpu_red_data_i : alu_red_data_i);
    check_bit("sldu_red_ready_o", sldu_red_ready_o,
              is_fpu ? fpu_red_in_ready_i : alu_red_in_ready_i);
    done = is_fpu ? fpu_red_done_i : alu_red_done_i;
    if (done) begin
      retire_head();
      alu_granted = 1'b0;
      fpu_granted = 1'b0;
    end else if (sldu_ready_i) begin
      // Answered by a done pulse on the next cycle
      if (is_fpu) begin
        fpu_granted = 1'b1;
      end else begin
        alu_granted = 1'b1;
      end
    end
  endtask

  task automatic check_bus();
    sel_e head;
    bit   is_alu;
    bit   is_fpu;
    if (!sldu_valid_o && !addrgen_valid_o) begin
      check_bit("alu_red_gnt_o", alu_red_gnt_o, 1'b0);
      check_bit("fpu_red_gnt_o", fpu_red_gnt_o, 1'b0);
      check_bit("alu_red_in_valid_o", alu_red_in_valid_o, 1'b0);
      check_bit("fpu_red_in_valid_o", fpu_red_in_valid_o, 1'b0);
      check_bit("sldu_red_ready_o", sldu_red_ready_o, 1'b0);
    end else begin
      check_true(sel_exp.size() != 0, "bus valid raised with no routed operation pending");
      if (sel_exp.size() != 0) begin
        head   = sel_exp[0];
        is_alu = (head == ALU_RED_SEL);
        is_fpu = (head == FPU_RED_SEL);
        check_bit("sldu_valid_o", sldu_valid_o, head != ADDRGEN_SEL);
        check_bit("addrgen_valid_o", addrgen_valid_o, head == ADDRGEN_SEL);
        check_bit("alu_red_gnt_o", alu_red_gnt_o, is_alu && sldu_ready_i);
        check_bit("fpu_red_gnt_o", fpu_red_gnt_o, is_fpu && sldu_ready_i);
        check_bit("alu_red_in_valid_o", alu_red_in_valid_o, is_alu && sldu_red_valid_i);
        check_bit("fpu_red_in_valid_o", fpu_red_in_valid_o, is_fpu && sldu_red_valid_i);
        case (head)
          SLDU_SEL:    take_operand(sldu_ready_i);
          ADDRGEN_SEL: take_operand(addrgen_ready_i);
          default:     take_reduction(is_fpu);
        endcase
      end
    end
  endtask

  // Transfers are judged on the values present at the rising edge
  always @(posedge clk_i) begin
    if (!arst_n_i || flush_i) begin
      clear_model();
    end else begin
      check_bus();
      if (op_valid_i && op_ready_o) begin
        record_op(op_i);
      end
      if (opq_valid_i && opq_ready_o) begin
        record_operand(opq_data_i, opq_last_i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Sink readiness, reduction data and done pulses
  initial begin : drive_sinks
    sldu_ready_i       = 1'b0;
    addrgen_ready_i    = 1'b0;
    alu_red_in_ready_i = 1'b0;
    fpu_red_in_ready_i = 1'b0;
    sldu_red_valid_i   = 1'b0;
    alu_red_data_i     = '0;
    fpu_red_data_i     = '0;
    alu_red_done_i     = 1'b0;
    fpu_red_done_i     = 1'b0;
    forever begin
      @(negedge clk_i);
      sldu_ready_i       = !hold_bus && ($urandom_range(99) < ready_pct);
      addrgen_ready_i    = !hold_bus && ($urandom_range(99) < ready_pct);
      alu_red_in_ready_i = ($urandom_range(1) == 1);
      fpu_red_in_ready_i = ($urandom_range(1) == 1);
      sldu_red_valid_i   = ($urandom_range(1) == 1);
      alu_red_data_i     = {$urandom, $urandom};
      fpu_red_data_i     = {$urandom, $urandom};
      alu_red_done_i     = alu_granted;
      fpu_red_done_i     = fpu_granted;
    end
  end

  task automatic push_op(ara_op_e op);
    @(negedge clk_i);
    while ($urandom_range(99) < IdlePct) begin
      op_valid_i = 1'b0;
      @(negedge clk_i);
    end
    op_valid_i = 1'b1;
    op_i       = op;
    @(posedge clk_i);
    while (!op_ready_o) @(posedge clk_i);
  endtask

  task automatic push_operand(opq_word_t word);
    @(negedge clk_i);
    while ($urandom_range(99) < IdlePct) begin
      opq_valid_i = 1'b0;
      @(negedge clk_i);
    end
    opq_valid_i = 1'b1;
    opq_data_i  = word.data;
    opq_last_i  = word.last;
    @(posedge clk_i);
    while (!opq_ready_o) @(posedge clk_i);
  endtask

  // Mode 0 slides, 1 indexed memory, 2 reductions, 3 any code
  function automatic ara_op_e pick_op(int mode);
    case (mode)
      0:       pick_op = ($urandom_range(1) == 1) ? VSLIDEDOWN : VSLIDEUP;
      1:       pick_op = ($urandom_range(1) == 1) ? VSXE : VLXE;
      2:       pick_op = ara_op_e'(5'(VREDSUM + $urandom_range(VFWREDOSUM - VREDSUM)));
      default: pick_op = ara_op_e'(5'($urandom_range(VFWREDOSUM)));
    endcase
  endfunction

  task automatic run_stream(int mode, int n);
    ara_op_e   ops[$];
    opq_word_t opds[$];
    opq_word_t word;
    sel_e      sel;
    int        k;
    for (int i = 0; i < n; i++) begin
      ops.push_back(pick_op(mode));
      if (route_of(ops[i], sel) && (sel inside {SLDU_SEL, ADDRGEN_SEL})) begin
        k = $urandom_range(4, 1);
        for (int j = 1; j <= k; j++) begin
          word.data = {$urandom, $urandom};
          word.last = (j == k);
          opds.push_back(word);
        end
      end
    end
    fork
      begin
        foreach (ops[i]) push_op(ops[i]);
        @(negedge clk_i);
        op_valid_i = 1'b0;
      end
      begin
        foreach (opds[i]) push_operand(opds[i]);
        @(negedge clk_i);
        opq_valid_i = 1'b0;
      end
    join
    while (!model_empty()) @(negedge clk_i);
    @(negedge clk_i);
    check_idle();
  endtask

  task automatic flush_midstream();
    opq_word_t word;
    @(posedge clk_i);
    hold_bus = 1'b1;
    push_op(VSLIDEUP);
    push_op(VREDSUM);
    push_op(VLXE);
    @(negedge clk_i);
    op_valid_i = 1'b0;
    for (int j = 0; j < 3; j++) begin
      word.data = {$urandom, $urandom};
      word.last = (j != 0);
      push_operand(word);
    end
    @(negedge clk_i);
    opq_valid_i = 1'b0;
    repeat (3) @(negedge clk_i);
    check_bit("sldu_valid_o", sldu_valid_o, 1'b1);
    // Reduction still sitting in the classifier stage when the flush hits
    op_valid_i = 1'b1;
    op_i       = VREDMAX;
    @(negedge clk_i);
    op_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    @(posedge clk_i);
    hold_bus = 1'b0;
    repeat (5) begin
      @(negedge clk_i);
      check_idle();
    end
    run_stream(3, FlushOps - 3);
  endtask

  task automatic close_test(string name, int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("[%0t ns] %-12s ok", $time, name);
    end else begin
      tests_bad++;
      $display("[%0t ns] %-12s FAILED with %0d errors", $time, name, errors - errs_before);
    end
  endtask

  initial begin : main
    int e0;
    void'($urandom(4));
    arst_n_i    = 1'b0;
    flush_i     = 1'b0;
    op_valid_i  = 1'b0;
    op_i        = VADD;
    opq_valid_i = 1'b0;
    opq_data_i  = '0;
    opq_last_i  = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    e0 = errors;
    @(negedge clk_i);
    check_idle();
    close_test("reset", e0);

    e0 = errors;
    run_stream(0, SlideOps);
    close_test("slide", e0);

    e0 = errors;
    run_stream(1, IndexOps);
    close_test("indexed", e0);

    e0 = errors;
    run_stream(2, RedOps);
    close_test("reduction", e0);

    // Heavier back-pressure for the mixed stream
    @(posedge clk_i);
    ready_pct = 40;
    e0 = errors;
    run_stream(3, MixOps);
    close_test("random mix", e0);

    e0 = errors;
    flush_midstream();
    close_test("flush", e0);

    $display("Tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_lane_operand_router

//--- src.f
+incdir+sim
src/lane_pkg.sv
src/op_classifier.sv
src/order_fifo.sv
src/operand_bus_arbiter.sv
src/lane_operand_router.sv
sim/tb_lane_operand_router.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the lane operand router testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG="$BUILD_DIR/sim.log"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -f src.f \
  --top-module tb_lane_operand_router -Mdir "$BUILD_DIR" -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
